/* src/cp0_tlb_pkg.sv */
`default_nettype none

package cp0_tlb_pkg;

	typedef logic [31:0] word_t;

	// upper 5 bits register number, low 3 bits select
	typedef logic [7:0] cp0_addr_t;

	// one-hot flags: int, rine, rdae, ades, sys, bp, ri, ov
	typedef logic [7:0] exc_vec_t;

	typedef logic [4:0] exccode_t;

	// vpn2, asid, g, even page {pfn, c, d, v}, odd page {pfn, c, d, v}
	typedef logic [77:0] tlb_entry_t;

	localparam logic [4:0] reg_index    = 5'd0;
	localparam logic [4:0] reg_entrylo0 = 5'd2;
	localparam logic [4:0] reg_entrylo1 = 5'd3;
	localparam logic [4:0] reg_badvaddr = 5'd8;
	localparam logic [4:0] reg_count    = 5'd9;
	localparam logic [4:0] reg_entryhi  = 5'd10;
	localparam logic [4:0] reg_compare  = 5'd11;
	localparam logic [4:0] reg_status   = 5'd12;
	localparam logic [4:0] reg_cause    = 5'd13;
	localparam logic [4:0] reg_epc      = 5'd14;

	localparam exccode_t exc_int  = 5'h00;
	localparam exccode_t exc_adel = 5'h04;
	localparam exccode_t exc_ades = 5'h05;
	localparam exccode_t exc_sys  = 5'h08;
	localparam exccode_t exc_bp   = 5'h09;
	localparam exccode_t exc_ri   = 5'h0a;
	localparam exccode_t exc_ov   = 5'h0c;

endpackage

`default_nettype wire

/* src/cp0_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_timer (
	input  logic                clk,
	input  logic                rst,
	input  logic                count_wen,
	input  logic                compare_wen,
	input  cp0_tlb_pkg::word_t  timer_wdata,
	output cp0_tlb_pkg::word_t  count,
	output cp0_tlb_pkg::word_t  compare,
	output logic                timer_int
);

	// count is the upper 32 bits, so it steps every other cycle
	logic [32:0] count_half;
	cp0_tlb_pkg::word_t compare_q;

	always_ff @(posedge clk) begin
		if (rst)
			count_half <= '0;
		else if (count_wen)
			count_half <= {timer_wdata, 1'b0};
		else
			count_half <= count_half + 33'd1;
	end

	// far from count after reset so no match fires early
	always_ff @(posedge clk) begin
		if (rst)
			compare_q <= '1;
		else if (compare_wen)
			compare_q <= timer_wdata;
	end

	// sticky until software rewrites compare
	always_ff @(posedge clk) begin
		if (rst)
			timer_int <= 1'b0;
		else if (compare_wen)
			timer_int <= 1'b0;
		else if (count_half[32:1] == compare_q)
			timer_int <= 1'b1;
	end

	assign count   = count_half[32:1];
	assign compare = compare_q;

endmodule

`default_nettype wire

/* src/tlb_array.sv */
`timescale 1ns/100ps
`default_nettype none

module tlb_array #(
	parameter int tlbnum = 16
) (
	input  logic                     clk,
	input  logic                     rst,
	input  cp0_tlb_pkg::word_t       entryhi,
	input  logic [$clog2(tlbnum)-1:0] tlb_index,
	input  logic                     tlb_we,
	input  cp0_tlb_pkg::tlb_entry_t  tlb_wentry,
	output cp0_tlb_pkg::tlb_entry_t  read_entry,
	output logic                     probe_hit,
	output logic [$clog2(tlbnum)-1:0] probe_index,
	input  cp0_tlb_pkg::word_t       xlat_vaddr,
	output cp0_tlb_pkg::word_t       xlat_paddr,
	output logic                     xlat_hit
);

	localparam int iw = $clog2(tlbnum);

	cp0_tlb_pkg::tlb_entry_t mem [tlbnum];
	logic [tlbnum-1:0] valid;

	logic [tlbnum-1:0] probe_match;
	logic [tlbnum-1:0] xlat_match;
	logic [iw-1:0] xlat_index;
	logic xlat_any;
	cp0_tlb_pkg::tlb_entry_t xlat_entry;
	logic [24:0] page;

	always_ff @(posedge clk) begin
		if (tlb_we)
			mem[tlb_index] <= tlb_wentry;
	end

	// an entry counts only once it has been written
	always_ff @(posedge clk) begin
		if (rst)
			valid <= '0;
		else if (tlb_we)
			valid[tlb_index] <= 1'b1;
	end

	// vpn2 compare plus asid compare unless global
	always_comb begin
		for (int i = 0; i < tlbnum; i++) begin
			probe_match[i] = valid[i]
				&& mem[i][77:59] == entryhi[31:13]
				&& (mem[i][50] || mem[i][58:51] == entryhi[7:0]);
			xlat_match[i] = valid[i]
				&& mem[i][77:59] == xlat_vaddr[31:13]
				&& (mem[i][50] || mem[i][58:51] == entryhi[7:0]);
		end
	end

	// lowest matching index wins
	always_comb begin
		probe_hit   = 1'b0;
		probe_index = '0;
		xlat_any    = 1'b0;
		xlat_index  = '0;
		for (int i = tlbnum - 1; i >= 0; i--) begin
			if (probe_match[i]) begin
				probe_hit   = 1'b1;
				probe_index = iw'(i);
			end
			if (xlat_match[i]) begin
				xlat_any   = 1'b1;
				xlat_index = iw'(i);
			end
		end
	end

	assign read_entry = mem[tlb_index];
	assign xlat_entry = mem[xlat_index];

	// vaddr bit 12 picks odd page
	assign page = xlat_vaddr[12] ? xlat_entry[24:0] : xlat_entry[49:25];

	assign xlat_paddr = {page[24:5], xlat_vaddr[11:0]};
	assign xlat_hit   = xlat_any && page[0];

endmodule

`default_nettype wire

/* src/cp0_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_regs #(
	parameter int tlbnum = 16
) (
	input  logic                      clk,
	input  logic                      rst,
	input  cp0_tlb_pkg::cp0_addr_t    cp0_addr,
	input  logic                      cp0_wen,
	input  cp0_tlb_pkg::word_t        cp0_wdata,
	output cp0_tlb_pkg::word_t        cp0_rdata,
	input  cp0_tlb_pkg::exc_vec_t     exc_type,
	input  cp0_tlb_pkg::word_t        pc,
	input  logic                      is_slot,
	input  cp0_tlb_pkg::word_t        bad_vaddr,
	input  logic [5:0]                int_num,
	input  logic                      eret,
	output cp0_tlb_pkg::word_t        epc,
	output logic                      int_happen,
	input  logic                      tlbp,
	input  logic                      tlbr,
	input  logic                      tlbwi,
	output logic                      count_wen,
	output logic                      compare_wen,
	output cp0_tlb_pkg::word_t        timer_wdata,
	input  cp0_tlb_pkg::word_t        count,
	input  cp0_tlb_pkg::word_t        compare,
	input  logic                      timer_int,
	output cp0_tlb_pkg::word_t        entryhi,
	output logic [$clog2(tlbnum)-1:0] tlb_index,
	output logic                      tlb_we,
	output cp0_tlb_pkg::tlb_entry_t   tlb_wentry,
	input  logic                      probe_hit,
	input  logic [$clog2(tlbnum)-1:0] probe_index,
	input  cp0_tlb_pkg::tlb_entry_t   read_entry
);

	localparam int iw = $clog2(tlbnum);

	logic [4:0] rnum;
	logic wr;
	logic any_exc, rec_exc;
	logic e_int, e_rine, e_rdae, e_ades, e_sys, e_bp, e_ri, e_ov;
	cp0_tlb_pkg::exccode_t exccode, cause_exccode;

	logic [7:0] status_im;
	logic status_exl, status_ie;
	logic cause_bd;
	logic [1:0] ip_sw;
	logic [5:0] ip_hw;
	logic [7:0] cause_ip;
	cp0_tlb_pkg::word_t epc_q, badvaddr_q;

	logic index_p;
	logic [iw-1:0] index_q;
	logic [18:0] hi_vpn2;
	logic [7:0] hi_asid;
	logic [29:0] lo0, lo1;

	// select must be zero for any register hit
	assign rnum = cp0_addr[7:3];
	assign wr   = cp0_wen && cp0_addr[2:0] == 3'b000;

	assign {e_int, e_rine, e_rdae, e_ades, e_sys, e_bp, e_ri, e_ov} = exc_type;
	assign any_exc = |exc_type;
	assign rec_exc = any_exc && !status_exl;

	always_comb begin
		if (e_int)
			exccode = cp0_tlb_pkg::exc_int;
		else if (e_rine)
			exccode = cp0_tlb_pkg::exc_adel;
		else if (e_ri)
			exccode = cp0_tlb_pkg::exc_ri;
		else if (e_sys)
			exccode = cp0_tlb_pkg::exc_sys;
		else if (e_bp)
			exccode = cp0_tlb_pkg::exc_bp;
		else if (e_ov)
			exccode = cp0_tlb_pkg::exc_ov;
		else if (e_rdae)
			exccode = cp0_tlb_pkg::exc_adel;
		else
			exccode = cp0_tlb_pkg::exc_ades;
	end

	always_ff @(posedge clk) begin
		if (wr && rnum == cp0_tlb_pkg::reg_status)
			status_im <= cp0_wdata[15:8];
	end

	// exception beats eret, eret beats software write
	always_ff @(posedge clk) begin
		if (rst)
			status_exl <= 1'b0;
		else if (any_exc)
			status_exl <= 1'b1;
		else if (eret)
			status_exl <= 1'b0;
		else if (wr && rnum == cp0_tlb_pkg::reg_status)
			status_exl <= cp0_wdata[1];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			status_ie     <= 1'b0;
			cause_bd      <= 1'b0;
			cause_exccode <= '0;
			ip_sw         <= '0;
			ip_hw         <= '0;
		end else begin
			ip_hw <= int_num;
			if (wr && rnum == cp0_tlb_pkg::reg_status)
				status_ie <= cp0_wdata[0];
			if (rec_exc)
				cause_bd <= is_slot;
			if (any_exc)
				cause_exccode <= exccode;
			if (wr && rnum == cp0_tlb_pkg::reg_cause)
				ip_sw <= cp0_wdata[9:8];
		end
	end

	// timer shares line 7 with int_num[5]
	assign cause_ip = {ip_hw[5] | timer_int, ip_hw[4:0], ip_sw};

	always_ff @(posedge clk) begin
		if (rec_exc)
			epc_q <= is_slot ? pc - 32'd4 : pc;
		else if (wr && rnum == cp0_tlb_pkg::reg_epc)
			epc_q <= cp0_wdata;
		if (e_rine || e_rdae || e_ades)
			badvaddr_q <= bad_vaddr;
	end

	assign int_happen = status_ie && !status_exl && |(status_im & cause_ip);
	assign epc        = epc_q;

	assign count_wen   = wr && rnum == cp0_tlb_pkg::reg_count;
	assign compare_wen = wr && rnum == cp0_tlb_pkg::reg_compare;
	assign timer_wdata = cp0_wdata;

	// p is only set by a probe miss
	always_ff @(posedge clk) begin
		if (tlbp) begin
			index_p <= !probe_hit;
			index_q <= probe_index;
		end else if (wr && rnum == cp0_tlb_pkg::reg_index) begin
			index_p <= 1'b0;
			index_q <= cp0_wdata[iw-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (tlbr) begin
			hi_vpn2 <= read_entry[77:59];
			hi_asid <= read_entry[58:51];
			lo0     <= {4'h0, read_entry[49:25], read_entry[50]};
			lo1     <= {4'h0, read_entry[24:0], read_entry[50]};
		end else begin
			if (wr && rnum == cp0_tlb_pkg::reg_entryhi) begin
				hi_vpn2 <= cp0_wdata[31:13];
				hi_asid <= cp0_wdata[7:0];
			end
			if (wr && rnum == cp0_tlb_pkg::reg_entrylo0)
				lo0 <= cp0_wdata[29:0];
			if (wr && rnum == cp0_tlb_pkg::reg_entrylo1)
				lo1 <= cp0_wdata[29:0];
		end
	end

	assign entryhi    = {hi_vpn2, 5'h00, hi_asid};
	assign tlb_index  = index_q;
	assign tlb_we     = tlbwi;
	assign tlb_wentry = {hi_vpn2, hi_asid, lo0[0] & lo1[0], lo0[25:1], lo1[25:1]};

	always_comb begin
		cp0_rdata = '0;
		if (cp0_addr[2:0] == 3'b000) begin
			case (rnum)
				cp0_tlb_pkg::reg_index:    cp0_rdata = {index_p, {(31 - iw){1'b0}}, index_q};
				cp0_tlb_pkg::reg_entrylo0: cp0_rdata = {2'b00, lo0};
				cp0_tlb_pkg::reg_entrylo1: cp0_rdata = {2'b00, lo1};
				cp0_tlb_pkg::reg_badvaddr: cp0_rdata = badvaddr_q;
				cp0_tlb_pkg::reg_count:    cp0_rdata = count;
				cp0_tlb_pkg::reg_entryhi:  cp0_rdata = entryhi;
				cp0_tlb_pkg::reg_compare:  cp0_rdata = compare;
				// bev reads as 1
				cp0_tlb_pkg::reg_status:
					cp0_rdata = {9'h0, 1'b1, 6'h0, status_im, 6'h0, status_exl, status_ie};
				cp0_tlb_pkg::reg_cause:
					cp0_rdata = {cause_bd, timer_int, 14'h0, cause_ip, 1'b0, cause_exccode, 2'b00};
				cp0_tlb_pkg::reg_epc:      cp0_rdata = epc_q;
				default:                   cp0_rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/cp0_tlb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_tlb_top #(
	parameter int tlbnum = 16
) (
	input  logic                   clk,
	input  logic                   rst,
	input  cp0_tlb_pkg::cp0_addr_t cp0_addr,
	input  logic                   cp0_wen,
	input  cp0_tlb_pkg::word_t     cp0_wdata,
	output cp0_tlb_pkg::word_t     cp0_rdata,
	input  cp0_tlb_pkg::exc_vec_t  exc_type,
	input  cp0_tlb_pkg::word_t     pc,
	input  cp0_tlb_pkg::word_t     bad_vaddr,
	input  logic                   is_slot,
	input  logic [5:0]             int_num,
	input  logic                   eret,
	input  logic                   tlbp,
	input  logic                   tlbr,
	input  logic                   tlbwi,
	output cp0_tlb_pkg::word_t     epc,
	output logic                   int_happen,
	input  cp0_tlb_pkg::word_t     xlat_vaddr,
	output cp0_tlb_pkg::word_t     xlat_paddr,
	output logic                   xlat_hit
);

	localparam int iw = $clog2(tlbnum);

	logic count_wen, compare_wen, timer_int;
	cp0_tlb_pkg::word_t timer_wdata, count, compare, entryhi;
	logic [iw-1:0] tlb_index, probe_index;
	logic tlb_we, probe_hit;
	cp0_tlb_pkg::tlb_entry_t tlb_wentry, read_entry;

	cp0_regs #(.tlbnum(tlbnum)) regs_i (
		.clk(clk), .rst(rst),
		.cp0_addr(cp0_addr), .cp0_wen(cp0_wen), .cp0_wdata(cp0_wdata), .cp0_rdata(cp0_rdata),
		.exc_type(exc_type), .pc(pc), .is_slot(is_slot), .bad_vaddr(bad_vaddr),
		.int_num(int_num), .eret(eret), .epc(epc), .int_happen(int_happen),
		.tlbp(tlbp), .tlbr(tlbr), .tlbwi(tlbwi),
		.count_wen(count_wen), .compare_wen(compare_wen), .timer_wdata(timer_wdata),
		.count(count), .compare(compare), .timer_int(timer_int),
		.entryhi(entryhi), .tlb_index(tlb_index), .tlb_we(tlb_we), .tlb_wentry(tlb_wentry),
		.probe_hit(probe_hit), .probe_index(probe_index), .read_entry(read_entry)
	);

	cp0_timer timer_i (
		.clk(clk), .rst(rst),
		.count_wen(count_wen), .compare_wen(compare_wen), .timer_wdata(timer_wdata),
		.count(count), .compare(compare), .timer_int(timer_int)
	);

	tlb_array #(.tlbnum(tlbnum)) tlb_i (
		.clk(clk), .rst(rst),
		.entryhi(entryhi), .tlb_index(tlb_index), .tlb_we(tlb_we), .tlb_wentry(tlb_wentry),
		.read_entry(read_entry), .probe_hit(probe_hit), .probe_index(probe_index),
		.xlat_vaddr(xlat_vaddr), .xlat_paddr(xlat_paddr), .xlat_hit(xlat_hit)
	);

endmodule

`default_nettype wire

/* bench/cp0_tlb_ref.svh */
// expected values from the shadow state of the testbench

function automatic cp0_tlb_pkg::exccode_t code_of(input cp0_tlb_pkg::exc_vec_t e);
	// bits: int, rine, rdae, ades, sys, bp, ri, ov
	if (e[7]) return cp0_tlb_pkg::exc_int;
	if (e[6]) return cp0_tlb_pkg::exc_adel;
	if (e[1]) return cp0_tlb_pkg::exc_ri;
	if (e[3]) return cp0_tlb_pkg::exc_sys;
	if (e[2]) return cp0_tlb_pkg::exc_bp;
	if (e[0]) return cp0_tlb_pkg::exc_ov;
	if (e[5]) return cp0_tlb_pkg::exc_adel;
	return cp0_tlb_pkg::exc_ades;
endfunction

function automatic cp0_tlb_pkg::word_t status_word();
	return {9'h0, 1'b1, 6'h0, s_im, 6'h0, s_exl, s_ie};
endfunction

function automatic logic [7:0] ip_bits(input logic tmr);
	return {s_iphw[5] | tmr, s_iphw[4:0], s_ipsw};
endfunction

function automatic cp0_tlb_pkg::word_t cause_word(input logic tmr);
	return {s_bd, tmr, 14'h0, ip_bits(tmr), 1'b0, s_code, 2'b00};
endfunction

function automatic logic int_req(input logic tmr);
	return s_ie && !s_exl && (|(s_im & ip_bits(tmr)));
endfunction

function automatic cp0_tlb_pkg::tlb_entry_t pack_entry();
	return {s_vpn2, s_asid, s_lo0[0] & s_lo1[0], s_lo0[25:1], s_lo1[25:1]};
endfunction

// lowest matching index, -1 on a miss
function automatic int lookup(input logic [18:0] vpn2, input logic [7:0] asid);
	for (int i = 0; i < 16; i++) begin
		if (s_valid[i] && s_tlb[i][77:59] == vpn2 && (s_tlb[i][50] || s_tlb[i][58:51] == asid))
			return i;
	end
	return -1;
endfunction

task automatic check_word(input string name, input cp0_tlb_pkg::word_t exp,
		input cp0_tlb_pkg::word_t act);
	if (exp !== act) begin
		$display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		$display("FAIL: see errors above");
		$fatal(1, "stopping at first error");
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (exp !== act) begin
		$display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
		$display("FAIL: see errors above");
		$fatal(1, "stopping at first error");
	end
endtask

/* bench/cp0_tlb_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_tlb_tb;

	localparam int max_cycles = 20000;

	logic clk, rst;
	cp0_tlb_pkg::cp0_addr_t cp0_addr;
	logic cp0_wen;
	cp0_tlb_pkg::word_t cp0_wdata, cp0_rdata, pc, bad_vaddr, epc, xlat_vaddr, xlat_paddr;
	cp0_tlb_pkg::exc_vec_t exc_type;
	logic is_slot, eret, tlbp, tlbr, tlbwi, int_happen, xlat_hit;
	logic [5:0] int_num;
	int cycles;

	// shadow state
	logic [7:0] s_im;
	logic s_exl, s_ie, s_bd, badv_known;
	logic [1:0] s_ipsw;
	logic [5:0] s_iphw;
	cp0_tlb_pkg::exccode_t s_code;
	cp0_tlb_pkg::word_t s_epc, s_badv;
	logic [18:0] s_vpn2;
	logic [7:0] s_asid;
	logic [29:0] s_lo0, s_lo1;
	cp0_tlb_pkg::tlb_entry_t s_tlb [16];
	logic [15:0] s_valid;

	`include "cp0_tlb_ref.svh"

	cp0_tlb_top #(.tlbnum(16)) dut_i (
		.clk(clk), .rst(rst),
		.cp0_addr(cp0_addr), .cp0_wen(cp0_wen), .cp0_wdata(cp0_wdata), .cp0_rdata(cp0_rdata),
		.exc_type(exc_type), .pc(pc), .bad_vaddr(bad_vaddr), .is_slot(is_slot),
		.int_num(int_num), .eret(eret), .tlbp(tlbp), .tlbr(tlbr), .tlbwi(tlbwi),
		.epc(epc), .int_happen(int_happen),
		.xlat_vaddr(xlat_vaddr), .xlat_paddr(xlat_paddr), .xlat_hit(xlat_hit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("FAIL: see errors above");
			$fatal(1, "timeout: tests did not finish within %0d cycles", max_cycles);
		end
	end

	task automatic write_reg(input logic [4:0] num, input logic [2:0] sel,
			input cp0_tlb_pkg::word_t d);
		@(negedge clk);
		cp0_addr  = {num, sel};
		cp0_wen   = 1'b1;
		cp0_wdata = d;
		@(negedge clk);
		cp0_wen = 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] num, output cp0_tlb_pkg::word_t d);
		cp0_addr = {num, 3'b000};
		#0.5;
		d = cp0_rdata;
	endtask

	task automatic read_check(input logic [4:0] num, input string name,
			input cp0_tlb_pkg::word_t exp);
		cp0_tlb_pkg::word_t d;
		read_reg(num, d);
		check_word(name, exp, d);
	endtask

	// 0 tlbp, 1 tlbr, 2 tlbwi, 3 eret
	task automatic strobe(input int op);
		@(negedge clk);
		tlbp  = op == 0;
		tlbr  = op == 1;
		tlbwi = op == 2;
		eret  = op == 3;
		@(negedge clk);
		{tlbp, tlbr, tlbwi, eret} = 4'b0000;
	endtask

	task automatic raise_exc(input cp0_tlb_pkg::exc_vec_t e, input cp0_tlb_pkg::word_t p,
			input logic slot, input cp0_tlb_pkg::word_t bad);
		@(negedge clk);
		exc_type  = e;
		pc        = p;
		is_slot   = slot;
		bad_vaddr = bad;
		@(negedge clk);
		exc_type = '0;
		if (!s_exl) begin
			s_epc = slot ? p - 32'd4 : p;
			s_bd  = slot;
		end
		s_exl  = 1'b1;
		s_code = code_of(e);
		if (e[6] || e[5] || e[4]) begin
			s_badv     = bad;
			badv_known = 1'b1;
		end
	endtask

	function automatic cp0_tlb_pkg::exc_vec_t rand_exc();
		cp0_tlb_pkg::exc_vec_t e;
		logic [31:0] r;
		r = $urandom();
		e = r[8] ? 8'h01 << r[2:0] : r[7:0];
		if (e == 8'h00)
			e = 8'h40;
		return e;
	endfunction

	task automatic test_regs();
		logic [31:0] w;
		for (int n = 0; n < 20; n++) begin
			w = $urandom();
			write_reg(cp0_tlb_pkg::reg_status, 3'd0, w);
			{s_im, s_exl, s_ie} = {w[15:8], w[1], w[0]};
			read_check(cp0_tlb_pkg::reg_status, "status", status_word());
			w = $urandom();
			write_reg(cp0_tlb_pkg::reg_cause, 3'd0, w);
			s_ipsw = w[9:8];
			read_check(cp0_tlb_pkg::reg_cause, "cause", cause_word(1'b0));
			w = $urandom();
			write_reg(cp0_tlb_pkg::reg_entryhi, 3'd0, w);
			read_check(cp0_tlb_pkg::reg_entryhi, "entryhi", w & 32'hffff_e0ff);
			w = $urandom();
			write_reg(cp0_tlb_pkg::reg_entrylo0, 3'd0, w);
			read_check(cp0_tlb_pkg::reg_entrylo0, "entrylo0", w & 32'h3fff_ffff);
			w = $urandom();
			write_reg(cp0_tlb_pkg::reg_entrylo1, 3'd0, w);
			read_check(cp0_tlb_pkg::reg_entrylo1, "entrylo1", w & 32'h3fff_ffff);
			w = $urandom();
			write_reg(cp0_tlb_pkg::reg_index, 3'd0, w);
			read_check(cp0_tlb_pkg::reg_index, "index", {28'h0, w[3:0]});
			w = $urandom();
			write_reg(cp0_tlb_pkg::reg_epc, 3'd0, w);
			s_epc = w;
			write_reg(cp0_tlb_pkg::reg_epc, 3'(1 + n % 7), ~w);
			read_check(cp0_tlb_pkg::reg_epc, "epc", s_epc);
		end
	endtask

	task automatic test_exc();
		cp0_tlb_pkg::word_t p;
		logic [31:0] r;
		write_reg(cp0_tlb_pkg::reg_status, 3'd0, 32'h0);
		{s_im, s_exl, s_ie} = '0;
		for (int n = 0; n < 24; n++) begin
			r = $urandom();
			p = {r[31:2], 2'b00};
			raise_exc(n == 0 ? 8'h10 : rand_exc(), p, r[0], $urandom());
			check_word("epc port", s_epc, epc);
			read_check(cp0_tlb_pkg::reg_cause, "cause", cause_word(1'b0));
			read_check(cp0_tlb_pkg::reg_status, "status", status_word());
			if (badv_known)
				read_check(cp0_tlb_pkg::reg_badvaddr, "badvaddr", s_badv);
			if (r[1]) begin
				raise_exc(rand_exc(), p + 32'd64, !r[0], $urandom());
				check_word("epc port", s_epc, epc);
				read_check(cp0_tlb_pkg::reg_cause, "cause", cause_word(1'b0));
				read_check(cp0_tlb_pkg::reg_badvaddr, "badvaddr", s_badv);
			end
			strobe(3);
			s_exl = 1'b0;
			read_check(cp0_tlb_pkg::reg_status, "status", status_word());
		end
	endtask

	task automatic test_int();
		logic [31:0] r;
		for (int n = 0; n < 40; n++) begin
			r = $urandom();
			write_reg(cp0_tlb_pkg::reg_status, 3'd0, {16'h0, r[7:0], 6'h0, r[9:8]});
			{s_im, s_exl, s_ie} = {r[7:0], r[9:8]};
			write_reg(cp0_tlb_pkg::reg_cause, 3'd0, {22'h0, r[11:10], 8'h0});
			s_ipsw = r[11:10];
			check_bit("int_happen", int_req(1'b0), int_happen);
			@(negedge clk);
			int_num = r[17:12];
			#1;
			check_bit("int_happen", int_req(1'b0), int_happen);
			@(negedge clk);
			s_iphw = r[17:12];
			#1;
			check_bit("int_happen", int_req(1'b0), int_happen);
			read_check(cp0_tlb_pkg::reg_cause, "cause", cause_word(1'b0));
		end
		int_num = 6'h0;
		repeat (2) @(negedge clk);
		s_iphw = 6'h0;
	endtask

	task automatic test_timer();
		cp0_tlb_pkg::word_t c, cnt, cause;
		int n;
		logic seen;
		for (int k = 0; k < 10; k++) begin
			c = {1'b0, 31'($urandom())};
			n = 2 + int'($urandom_range(0, 38));
			write_reg(cp0_tlb_pkg::reg_count, 3'd0, c);
			read_check(cp0_tlb_pkg::reg_count, "count", c);
			repeat (n) @(negedge clk);
			read_check(cp0_tlb_pkg::reg_count, "count", c + 32'(n / 2));
		end
		c = {1'b0, 31'($urandom())};
		write_reg(cp0_tlb_pkg::reg_count, 3'd0, c);
		write_reg(cp0_tlb_pkg::reg_compare, 3'd0, c + 32'd5);
		read_check(cp0_tlb_pkg::reg_compare, "compare", c + 32'd5);
		seen = 1'b0;
		for (int w = 0; w < 20 && !seen; w++) begin
			@(negedge clk);
			read_reg(cp0_tlb_pkg::reg_count, cnt);
			read_reg(cp0_tlb_pkg::reg_cause, cause);
			seen = cause[30];
			if (!seen && cnt > c + 32'd5)
				check_bit("cause.ti", 1'b1, cause[30]);
			if (seen) begin
				check_word("count", c + 32'd5, cnt);
				check_bit("cause.ip7", 1'b1, cause[15]);
			end else begin
				check_bit("cause.ip7", 1'b0, cause[15]);
			end
		end
		if (!seen) begin
			$display("FAIL: see errors above");
			$fatal(1, "timer interrupt never set after count reached compare");
		end
		write_reg(cp0_tlb_pkg::reg_compare, 3'd0, c + 32'd4000);
		read_check(cp0_tlb_pkg::reg_compare, "compare", c + 32'd4000);
		read_reg(cp0_tlb_pkg::reg_cause, cause);
		check_bit("cause.ti", 1'b0, cause[30]);
		check_bit("cause.ip7", 1'b0, cause[15]);
	endtask

	task automatic test_tlb();
		logic [31:0] r, va;
		cp0_tlb_pkg::tlb_entry_t e;
		logic [24:0] page;
		int k;
		for (int i = 0; i < 16; i++) begin
			r = $urandom();
			s_vpn2 = {16'h0, r[2:0]};
			s_asid = {6'h0, r[4:3]};
			write_reg(cp0_tlb_pkg::reg_entryhi, 3'd0, {s_vpn2, r[12:8], s_asid});
			r = $urandom();
			s_lo0 = r[29:0];
			write_reg(cp0_tlb_pkg::reg_entrylo0, 3'd0, r);
			r = $urandom();
			s_lo1 = r[29:0];
			write_reg(cp0_tlb_pkg::reg_entrylo1, 3'd0, r);
			write_reg(cp0_tlb_pkg::reg_index, 3'd0, 32'(i));
			strobe(2);
			s_tlb[i]   = pack_entry();
			s_valid[i] = 1'b1;
		end
		for (int i = 0; i < 16; i++) begin
			write_reg(cp0_tlb_pkg::reg_index, 3'd0, 32'(i));
			strobe(1);
			e = s_tlb[i];
			read_check(cp0_tlb_pkg::reg_entryhi, "entryhi", {e[77:59], 5'h0, e[58:51]});
			read_check(cp0_tlb_pkg::reg_entrylo0, "entrylo0", {6'h0, e[49:25], e[50]});
			read_check(cp0_tlb_pkg::reg_entrylo1, "entrylo1", {6'h0, e[24:0], e[50]});
			s_vpn2 = e[77:59];
			s_asid = e[58:51];
		end
		for (int n = 0; n < 30; n++) begin
			s_vpn2 = 19'($urandom_range(0, 9));
			s_asid = 8'($urandom_range(0, 3));
			write_reg(cp0_tlb_pkg::reg_entryhi, 3'd0, {s_vpn2, 5'h0, s_asid});
			strobe(0);
			k = lookup(s_vpn2, s_asid);
			read_check(cp0_tlb_pkg::reg_index, "index",
				k >= 0 ? {28'h0, 4'(k)} : 32'h8000_0000);
			for (int m = 0; m < 4; m++) begin
				r = $urandom();
				va = {19'($urandom_range(0, 9)), r[12:0]};
				@(negedge clk);
				xlat_vaddr = va;
				#1;
				k = lookup(va[31:13], s_asid);
				page = '0;
				if (k >= 0)
					page = va[12] ? s_tlb[k][24:0] : s_tlb[k][49:25];
				check_bit("xlat_hit", k >= 0 && page[0], xlat_hit);
				if (k >= 0 && page[0])
					check_word("xlat_paddr", {page[24:5], va[11:0]}, xlat_paddr);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h7191_bc46));
		rst = 1'b1;
		cycles = 0;
		cp0_addr = '0;
		cp0_wen = 1'b0;
		cp0_wdata = '0;
		exc_type = '0;
		pc = '0;
		is_slot = 1'b0;
		bad_vaddr = '0;
		int_num = '0;
		{eret, tlbp, tlbr, tlbwi} = 4'b0000;
		xlat_vaddr = '0;
		{s_bd, s_ipsw, s_iphw, s_code, badv_known, s_valid} = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		for (int n = 0; n < 8; n++) begin
			@(negedge clk);
			xlat_vaddr = $urandom();
			#1;
			check_bit("xlat_hit after reset", 1'b0, xlat_hit);
		end
		check_bit("int_happen after reset", 1'b0, int_happen);
		test_regs();
		test_exc();
		test_int();
		test_timer();
		test_tlb();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* cp0_tlb_top.f */
+incdir+bench
src/cp0_tlb_pkg.sv
src/cp0_timer.sv
src/tlb_array.sv
src/cp0_regs.sv
src/cp0_tlb_top.sv
bench/cp0_tlb_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= cp0_tlb_top.f
TB_TOP    ?= cp0_tlb_tb
RTL_TOP   ?= cp0_tlb_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
SIM_BIN   ?= sim_$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
